// ==== source/tlp_bridge_defs.svh ====
/*
 * Widths and core sideband bit positions for the 128-bit TLP path.
 * The receive user-field layout follows the 7-series 128-bit core.
 * Changing TLP_DATA_W alone is not supported.
 */

`ifndef TLP_BRIDGE_DEFS_SVH
`define TLP_BRIDGE_DEFS_SVH

// ----------------------------------------------------------------------
// Beat geometry
// ----------------------------------------------------------------------
`define TLP_DATA_W              128
`define TLP_DW_PER_BEAT         4
`define TLP_BYTE_KEEP_W         16

// ----------------------------------------------------------------------
// Core receive sideband
// ----------------------------------------------------------------------
`define CORE_RX_USER_W          22
`define BAR_HIT_W               7
`define RX_USER_SOF_BIT         14
`define RX_USER_SOF_HI_BIT      13
`define RX_USER_EOF_BIT         21
`define RX_USER_EOF_DW_HI       20
`define RX_USER_EOF_DW_LO       19
`define RX_USER_BAR_HI          8
`define RX_USER_BAR_LO          2

// Counter bit for the link-down blink
`define LED_HEARTBEAT_BIT_DEFAULT 25

`endif

// ==== source/pcie_core_pkg.sv ====
/*
 * Beat types on the PCIe core streaming side.
 * Receive user field is decoded by the realigner, not here.
 */

`include "tlp_bridge_defs.svh"

package pcie_core_pkg;

    // ----------------------------------------------------------------------
    // Plain vector types
    // ----------------------------------------------------------------------

    // One 128-bit beat, DW0 in the low 32 bits
    typedef logic [`TLP_DATA_W-1:0] tlp_data_t;

    // Receive sideband from the core
    typedef logic [`CORE_RX_USER_W-1:0] core_rx_user_t;

    // One bit per byte of a beat
    typedef logic [`TLP_BYTE_KEEP_W-1:0] byte_keep_t;

    // ----------------------------------------------------------------------
    // Beats
    // ----------------------------------------------------------------------

    // Driven by the core toward the user logic
    typedef struct packed {
        tlp_data_t     data;
        core_rx_user_t user;
        logic          valid;
    } core_rx_beat_t;

    // Driven toward the core transmit port
    typedef struct packed {
        tlp_data_t  data;
        byte_keep_t keep;
        logic       last;
        logic       valid;
    } core_tx_beat_t;

endpackage

// ==== source/tlp_stream_pkg.sv ====
/*
 * User-side TLP stream beat.
 * Data is always DW0-aligned; keep marks valid dwords from DW0 upward.
 */

`include "tlp_bridge_defs.svh"

package tlp_stream_pkg;

    // One bit per dword of a beat
    typedef logic [`TLP_DW_PER_BEAT-1:0] dw_keep_t;

    // BAR hit flags as reported by the core
    typedef logic [`BAR_HIT_W-1:0] bar_hit_t;

    // ----------------------------------------------------------------------
    // Stream beat
    // ----------------------------------------------------------------------
    // first and last mark the TLP boundaries, bar_hit is only
    // meaningful on receive
    typedef struct packed {
        pcie_core_pkg::tlp_data_t data;
        dw_keep_t                 keep;
        logic                     first;
        logic                     last;
        bar_hit_t                 bar_hit;
        logic                     valid;
    } tlp_beat_t;

endpackage

// ==== source/tlp_rx_realign.sv ====
/*
 * Turns core receive beats into DW0-aligned TLP beats.
 * Output has no back-pressure; every valid cycle is a delivered beat.
 * A TLP starting at DW2 lags by one accepted input beat, and may stall
 * the core for one cycle at its end.
 */

`timescale 1ns/1ps
`include "tlp_bridge_defs.svh"

module tlp_rx_realign (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  pcie_core_pkg::core_rx_beat_t core_rx,
    output logic                         core_rx_ready,
    output tlp_stream_pkg::tlp_beat_t    rx_tlp
);

    import pcie_core_pkg::*;
    import tlp_stream_pkg::*;

    localparam int QW_W = `TLP_DATA_W / 2;

    // Decoded input beat
    core_rx_user_t   in_user;
    logic            in_fire;
    logic [QW_W-1:0] in_qw0;
    logic [QW_W-1:0] in_qw1;
    logic            in_sof;
    logic            in_sof_hi;
    logic            in_eof;
    logic [1:0]      in_eof_dw;
    bar_hit_t        in_bar;
    logic            in_start_hi;
    logic            in_end_hi;

    // Held upper quadword and its flags
    logic [QW_W-1:0] held_qw;
    logic            held_sof;
    logic            held_eof;
    logic            held_eof_dw3;
    bar_hit_t        held_bar;
    logic            held_valid;
    logic            held_next;

    logic            ready_q;
    logic            stall;

    // ----------------------------------------------------------------------
    // Sideband decode
    // ----------------------------------------------------------------------
    assign in_user     = core_rx.user;
    assign in_fire     = core_rx.valid && ready_q;
    assign in_qw0      = core_rx.data[QW_W-1:0];
    assign in_qw1      = core_rx.data[`TLP_DATA_W-1:QW_W];
    assign in_sof      = in_user[`RX_USER_SOF_BIT];
    assign in_sof_hi   = in_user[`RX_USER_SOF_HI_BIT];
    assign in_eof      = in_user[`RX_USER_EOF_BIT];
    assign in_eof_dw   = in_user[`RX_USER_EOF_DW_HI:`RX_USER_EOF_DW_LO];
    assign in_bar      = in_user[`RX_USER_BAR_HI:`RX_USER_BAR_LO];
    assign in_start_hi = in_sof && in_sof_hi;
    assign in_end_hi   = in_eof && in_eof_dw[1];

    // Held half plus an end in the upper half needs one extra output beat
    assign stall = held_valid && in_fire && in_end_hi;

    // Keep the upper half whenever the TLP is running shifted,
    // also across idle core cycles inside the TLP
    assign held_next = in_fire ? (held_valid ?
                       ((!in_sof && !in_eof) || in_start_hi || in_end_hi) :
                       in_start_hi) :
                       (held_valid && !held_eof);

    assign core_rx_ready = ready_q;

    // ----------------------------------------------------------------------
    // Control state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            held_valid <= 1'b0;
            ready_q    <= 1'b1;
        end else begin
            held_valid <= held_next;
            ready_q    <= !stall;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (in_fire) begin
            held_qw      <= in_qw1;
            held_sof     <= in_start_hi;
            held_eof     <= in_end_hi;
            held_eof_dw3 <= (in_eof_dw == 2'd3);
            held_bar     <= in_bar;
        end
    end

    // ----------------------------------------------------------------------
    // Output beat
    // ----------------------------------------------------------------------
    always_comb begin
        rx_tlp.valid = held_valid ? (held_eof || in_fire) :
                       (in_fire && (in_eof || !in_start_hi));
        if (held_valid) begin
            // Held quadword goes below the incoming low quadword
            rx_tlp.data    = {in_qw0, held_qw};
            rx_tlp.first   = held_sof;
            rx_tlp.last    = held_eof || (in_fire && in_eof && !in_eof_dw[1]);
            rx_tlp.bar_hit = held_bar;
            rx_tlp.keep[0] = 1'b1;
            rx_tlp.keep[1] = !held_eof || held_eof_dw3;
            rx_tlp.keep[2] = !held_eof && in_fire;
            rx_tlp.keep[3] = !held_eof && in_fire && (!in_eof || (in_eof_dw != 2'd0));
        end else begin
            rx_tlp.data    = core_rx.data;
            rx_tlp.first   = in_sof && !in_sof_hi;
            rx_tlp.last    = in_eof;
            rx_tlp.bar_hit = in_bar;
            for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
                rx_tlp.keep[i] = in_fire && (!in_eof || (int'(in_eof_dw) >= i));
            end
        end
    end

endmodule

// ==== source/tlp_tx_skid.sv ====
/*
 * One-entry skid between the user TLP stream and the core transmit port.
 * No added latency while the core is ready; tx_tlp_ready is low while
 * a beat is stored. bar_hit of the user beat is not forwarded.
 */

`timescale 1ns/1ps
`include "tlp_bridge_defs.svh"

module tlp_tx_skid (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  tlp_stream_pkg::tlp_beat_t    tx_tlp,
    output logic                         tx_tlp_ready,
    output pcie_core_pkg::core_tx_beat_t core_tx,
    input  logic                         core_tx_ready
);

    import pcie_core_pkg::*;
    import tlp_stream_pkg::*;

    localparam int BYTES_PER_DW = `TLP_BYTE_KEEP_W / `TLP_DW_PER_BEAT;

    tlp_beat_t  held_beat;
    logic       held_valid;
    tlp_beat_t  out_beat;
    byte_keep_t byte_keep;

    assign tx_tlp_ready = !held_valid;

    // Stored beat goes out before anything new
    assign out_beat = held_valid ? held_beat : tx_tlp;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (held_valid) begin
            held_valid <= !core_tx_ready;
        end else begin
            held_valid <= tx_tlp.valid && !core_tx_ready;
        end
    end

    // Capture only when the core refuses a fresh beat
    always_ff @(posedge clk_pcie) begin
        if (!held_valid && tx_tlp.valid && !core_tx_ready) begin
            held_beat <= tx_tlp;
        end
    end

    // ----------------------------------------------------------------------
    // Dword keep to byte keep
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
            byte_keep[i*BYTES_PER_DW +: BYTES_PER_DW] = {BYTES_PER_DW{out_beat.keep[i]}};
        end
    end

    always_comb begin
        core_tx.data  = out_beat.data;
        core_tx.keep  = byte_keep;
        core_tx.last  = out_beat.last;
        core_tx.valid = held_valid || tx_tlp.valid;
    end

endmodule

// ==== source/link_state_led.sv ====
/*
 * State LED: steady on with link up, blinking from a free-running
 * counter otherwise. Blink half-period is 2**HEARTBEAT_BIT cycles.
 */

`timescale 1ns/1ps
`include "tlp_bridge_defs.svh"

module link_state_led #(
    parameter int HEARTBEAT_BIT = `LED_HEARTBEAT_BIT_DEFAULT
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    output logic led_state
);

    // Free-running heartbeat counter
    logic [HEARTBEAT_BIT:0] beat_cnt;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Link up overrides the blink
    assign led_state = link_up || beat_cnt[HEARTBEAT_BIT];

endmodule

// ==== source/pcie_tlp_bridge.sv ====
/*
 * User-side TLP path of a 128-bit PCIe endpoint wrapper.
 * Single clock domain on clk_pcie; the core itself sits outside.
 * Any of rst, core_user_reset or subsys_reset resets the subsystem.
 */

`timescale 1ns/1ps
`include "tlp_bridge_defs.svh"

module pcie_tlp_bridge #(
    parameter int HEARTBEAT_BIT = `LED_HEARTBEAT_BIT_DEFAULT
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic                         subsys_reset,
    input  logic                         core_user_reset,
    input  logic                         link_up,

    // Core receive side and user receive stream
    input  pcie_core_pkg::core_rx_beat_t core_rx,
    output logic                         core_rx_ready,
    output tlp_stream_pkg::tlp_beat_t    rx_tlp,

    // User transmit stream and core transmit side
    input  tlp_stream_pkg::tlp_beat_t    tx_tlp,
    output logic                         tx_tlp_ready,
    output pcie_core_pkg::core_tx_beat_t core_tx,
    input  logic                         core_tx_ready,

    output logic                         led_state
);

    logic rst_subsys;

    // ----------------------------------------------------------------------
    // Reset combining
    // ----------------------------------------------------------------------
    assign rst_subsys = rst || core_user_reset || subsys_reset;

    // ----------------------------------------------------------------------
    // Receive path
    // ----------------------------------------------------------------------
    tlp_rx_realign tlp_rx_realign_i (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst_subsys    ),
        .core_rx       ( core_rx       ),
        .core_rx_ready ( core_rx_ready ),
        .rx_tlp        ( rx_tlp        )
    );

    // ----------------------------------------------------------------------
    // Transmit path
    // ----------------------------------------------------------------------
    tlp_tx_skid tlp_tx_skid_i (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst_subsys    ),
        .tx_tlp        ( tx_tlp        ),
        .tx_tlp_ready  ( tx_tlp_ready  ),
        .core_tx       ( core_tx       ),
        .core_tx_ready ( core_tx_ready )
    );

    // State LED
    link_state_led #(
        .HEARTBEAT_BIT ( HEARTBEAT_BIT )
    ) link_state_led_i (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst_subsys    ),
        .link_up       ( link_up       ),
        .led_state     ( led_state     )
    );

endmodule

// ==== testbench/tb_pcie_tlp_bridge.sv ====
/*
 * Testbench for pcie_tlp_bridge with HEARTBEAT_BIT set to 4.
 * Inputs change 5 ns after the rising edge, outputs are sampled on the
 * falling edge. Receive TLPs starting at DW2 carry at least 3 dwords.
 */

`timescale 1ns/1ps
`include "tlp_bridge_defs.svh"

module tb_pcie_tlp_bridge;

    import pcie_core_pkg::*;
    import tlp_stream_pkg::*;

    localparam int CLK_HALF   = 50;
    localparam int WAIT_LIMIT = 50;
    localparam int SEED       = 32'h235f_5f94;

    logic          clk_pcie;
    logic          rst;
    logic          subsys_reset;
    logic          core_user_reset;
    logic          link_up;
    core_rx_beat_t core_rx;
    logic          core_rx_ready;
    tlp_beat_t     rx_tlp;
    tlp_beat_t     tx_tlp;
    logic          tx_tlp_ready;
    core_tx_beat_t core_tx;
    logic          core_tx_ready;
    logic          led_state;

    // Reference queues and scoreboard state
    logic [31:0]   rx_exp_q[$];
    tlp_data_t     rx_sent_q[$];
    tlp_beat_t     rx_out_q[$];
    tlp_beat_t     tx_exp_q[$];
    core_tx_beat_t tx_out_q[$];
    int            rx_stall_cnt;
    logic          tx_held;
    logic          tx_rand_en;
    int            err_cnt;
    int            test_cnt;
    int            test_err_base;

    pcie_tlp_bridge #(
        .HEARTBEAT_BIT   ( 4               )
    ) pcie_tlp_bridge_i (
        .clk_pcie        ( clk_pcie        ),
        .rst             ( rst             ),
        .subsys_reset    ( subsys_reset    ),
        .core_user_reset ( core_user_reset ),
        .link_up         ( link_up         ),
        .core_rx         ( core_rx         ),
        .core_rx_ready   ( core_rx_ready   ),
        .rx_tlp          ( rx_tlp          ),
        .tx_tlp          ( tx_tlp          ),
        .tx_tlp_ready    ( tx_tlp_ready    ),
        .core_tx         ( core_tx         ),
        .core_tx_ready   ( core_tx_ready   ),
        .led_state       ( led_state       )
    );

    always #CLK_HALF clk_pcie = ~clk_pcie;

    // Core transmit back-pressure, random only during the transmit test
    always @(posedge clk_pcie) begin
        #5;
        if (tx_rand_en) begin
            core_tx_ready = ($urandom % 8) < 5;
        end else begin
            core_tx_ready = 1'b1;
        end
    end

    task automatic log_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic log_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic next_cycle();
        @(posedge clk_pcie);
        #5;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (err_cnt == test_err_base) ? "ok" : "failed", err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ----------------------------------------------------------------------
    // Output monitors, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk_pcie) begin
        if (rst) begin
            tx_held = 1'b0;
        end else begin
            if (rx_tlp.valid) begin
                rx_out_q.push_back(rx_tlp);
            end
            if (!core_rx_ready) begin
                rx_stall_cnt++;
            end
            if (core_tx.valid && core_tx_ready) begin
                tx_out_q.push_back(core_tx);
            end
            assert (tx_tlp_ready == !tx_held)
                else log_error($sformatf("tx_tlp_ready %b with held beat %b",
                                         tx_tlp_ready, tx_held));
            // Without a held beat the core sees the user beat directly
            assert (tx_held || (core_tx.valid == tx_tlp.valid &&
                                (!tx_tlp.valid || core_tx.data == tx_tlp.data)))
                else log_error("core_tx differs from tx_tlp with nothing held");
            if (tx_held) begin
                tx_held = !core_tx_ready;
            end else begin
                tx_held = tx_tlp.valid && !core_tx_ready;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Reset inputs, seen through the LED counter restart
    // ----------------------------------------------------------------------
    task automatic check_reset_input(input logic use_core_reset);
        int waited;
        waited = 0;
        while (!led_state && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!led_state) begin
            log_failure("Timeout: led_state never rose before a reset pulse");
        end
        if (use_core_reset) begin
            core_user_reset = 1'b1;
        end else begin
            subsys_reset = 1'b1;
        end
        next_cycle();
        core_user_reset = 1'b0;
        subsys_reset    = 1'b0;
        @(negedge clk_pcie);
        assert (!led_state)
            else log_error($sformatf("led_state %b after a %s pulse", led_state,
                                     use_core_reset ? "core_user_reset" : "subsys_reset"));
        next_cycle();
    endtask

    // ----------------------------------------------------------------------
    // Receive stimulus and checking
    // ----------------------------------------------------------------------
    task automatic rx_beat(input tlp_data_t data, input core_rx_user_t user);
        int   waited;
        logic taken;
        core_rx.data  = data;
        core_rx.user  = user;
        core_rx.valid = 1'b1;
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk_pcie);
            taken = core_rx_ready;
            next_cycle();
            waited++;
        end
        if (!taken) begin
            log_failure("Timeout: core_rx_ready stayed low for a receive beat");
        end
    endtask

    task automatic send_rx_tlp(input logic start_hi, input int len, input bar_hit_t bar);
        int            first_slot;
        int            total;
        int            nbeats;
        tlp_data_t     data;
        core_rx_user_t user;
        first_slot   = start_hi ? 2 : 0;
        total        = first_slot + len;
        nbeats       = (total + 3) / 4;
        rx_stall_cnt = 0;
        for (int b = 0; b < nbeats; b++) begin
            user = '0;
            for (int k = 0; k < 4; k++) begin
                data[k*32 +: 32] = $urandom;
                if (b * 4 + k >= first_slot && b * 4 + k < total) begin
                    rx_exp_q.push_back(data[k*32 +: 32]);
                end
            end
            user[`RX_USER_SOF_BIT]    = (b == 0);
            user[`RX_USER_SOF_HI_BIT] = (b == 0) && start_hi;
            user[`RX_USER_EOF_BIT]    = (b == nbeats - 1);
            if (b == nbeats - 1) begin
                user[`RX_USER_EOF_DW_HI:`RX_USER_EOF_DW_LO] = 2'((total - 1) % 4);
            end
            user[`RX_USER_BAR_HI:`RX_USER_BAR_LO] = bar;
            rx_sent_q.push_back(data);
            rx_beat(data, user);
            // Idle core cycles inside a TLP
            if (b < nbeats - 1 && $urandom % 4 == 0) begin
                core_rx.valid = 1'b0;
                next_cycle();
            end
        end
        core_rx.valid = 1'b0;
    endtask

    task automatic check_rx_tlp(input logic start_hi, input int len, input bar_hit_t bar);
        int          waited;
        int          end_dw;
        int          exp_stall;
        int          nout;
        logic [31:0] got_q[$];
        dw_keep_t    exp_keep;
        tlp_beat_t   beat;
        waited = 0;
        while (!(rx_out_q.size() > 0 && rx_out_q[$].last) && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            log_failure("Timeout: the last beat of a receive TLP never appeared");
        end
        // Let a possible stall run out before counting it
        next_cycle();
        next_cycle();
        end_dw    = ((start_hi ? 2 : 0) + len - 1) % 4;
        exp_stall = (start_hi && end_dw >= 2) ? 1 : 0;
        nout      = rx_out_q.size();
        assert (rx_stall_cnt == exp_stall)
            else log_error($sformatf("core_rx_ready low %0d cycles, expected %0d",
                                     rx_stall_cnt, exp_stall));
        foreach (rx_out_q[i]) begin
            beat = rx_out_q[i];
            assert (beat.first == (i == 0) && beat.last == (i == nout - 1))
                else log_error($sformatf("beat %0d first %b last %b", i, beat.first, beat.last));
            assert (beat.bar_hit == bar)
                else log_error($sformatf("bar hit %h, expected %h", beat.bar_hit, bar));
            assert (beat.keep inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
                else log_error($sformatf("keep %b is not DW0-aligned", beat.keep));
            for (int k = 0; k < 4; k++) begin
                if (beat.keep[k]) begin
                    got_q.push_back(beat.data[k*32 +: 32]);
                end
                exp_keep[k] = (i < nout - 1) || (k <= end_dw);
            end
            if (!start_hi) begin
                assert (beat.data == rx_sent_q[i] && beat.keep == exp_keep)
                    else log_error($sformatf("aligned beat %0d differs, keep %b expected %b",
                                             i, beat.keep, exp_keep));
            end
        end
        if (!start_hi) begin
            assert (nout == rx_sent_q.size())
                else log_error($sformatf("%0d output beats for %0d input beats",
                                         nout, rx_sent_q.size()));
        end
        assert (got_q.size() == rx_exp_q.size())
            else log_error($sformatf("%0d dwords received, %0d sent",
                                     got_q.size(), rx_exp_q.size()));
        foreach (got_q[i]) begin
            if (i < rx_exp_q.size()) begin
                assert (got_q[i] == rx_exp_q[i])
                    else log_error($sformatf("dword %0d is %h, expected %h",
                                             i, got_q[i], rx_exp_q[i]));
            end
        end
        rx_exp_q.delete();
        rx_sent_q.delete();
        rx_out_q.delete();
    endtask

    // ----------------------------------------------------------------------
    // Transmit stimulus and checking
    // ----------------------------------------------------------------------
    task automatic send_tx_beat(input tlp_beat_t beat);
        int   waited;
        logic taken;
        tx_tlp       = beat;
        tx_tlp.valid = 1'b1;
        tx_exp_q.push_back(tx_tlp);
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk_pcie);
            taken = tx_tlp_ready;
            next_cycle();
            waited++;
        end
        if (!taken) begin
            log_failure("Timeout: tx_tlp_ready stayed low for a transmit beat");
        end
        tx_tlp.valid = 1'b0;
    endtask

    task automatic run_tx_test();
        tlp_beat_t     beat;
        core_tx_beat_t got;
        byte_keep_t    exp_bytes;
        int            last_dw;
        int            waited;
        tx_rand_en = 1'b1;
        for (int n = 0; n < 40; n++) begin
            beat         = '0;
            beat.data    = {$urandom, $urandom, $urandom, $urandom};
            beat.last    = (n == 39) || ($urandom % 3 == 0);
            last_dw      = beat.last ? int'($urandom % 4) : 3;
            beat.bar_hit = bar_hit_t'($urandom);
            for (int k = 0; k < 4; k++) begin
                beat.keep[k] = (k <= last_dw);
            end
            send_tx_beat(beat);
            if ($urandom % 4 == 0) begin
                next_cycle();
            end
        end
        waited = 0;
        while (tx_out_q.size() < tx_exp_q.size() && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            log_failure("Timeout: the core transmit port never drained");
        end
        tx_rand_en = 1'b0;
        next_cycle();
        assert (tx_out_q.size() == tx_exp_q.size())
            else log_error($sformatf("%0d beats at the core, %0d sent",
                                     tx_out_q.size(), tx_exp_q.size()));
        foreach (tx_out_q[i]) begin
            if (i < tx_exp_q.size()) begin
                beat = tx_exp_q[i];
                got  = tx_out_q[i];
                for (int k = 0; k < 16; k++) begin
                    exp_bytes[k] = beat.keep[k / 4];
                end
                assert (got.data == beat.data && got.keep == exp_bytes && got.last == beat.last)
                    else log_error($sformatf("core beat %0d differs, keep %h expected %h",
                                             i, got.keep, exp_bytes));
            end
        end
        tx_exp_q.delete();
        tx_out_q.delete();
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int       len;
        bar_hit_t bar;
        logic     last_led;
        int       run_len;
        int       toggles;
        void'($urandom(SEED));
        clk_pcie        = 1'b0;
        rst             = 1'b1;
        subsys_reset    = 1'b0;
        core_user_reset = 1'b0;
        link_up         = 1'b0;
        core_rx         = '0;
        tx_tlp          = '0;
        core_tx_ready   = 1'b1;
        tx_held         = 1'b0;
        tx_rand_en      = 1'b0;
        rx_stall_cnt    = 0;
        err_cnt         = 0;
        test_cnt        = 0;
        test_err_base   = 0;
        // A DW2 start offered during reset must leave nothing held
        core_rx.valid                     = 1'b1;
        core_rx.user[`RX_USER_SOF_BIT]    = 1'b1;
        core_rx.user[`RX_USER_SOF_HI_BIT] = 1'b1;
        repeat (10) @(posedge clk_pcie);
        #5;
        rst     = 1'b0;
        core_rx = '0;

        @(negedge clk_pcie);
        assert (!rx_tlp.valid && !core_tx.valid && core_rx_ready)
            else log_error("outputs not in their reset state");
        next_cycle();
        check_reset_input(1'b1);
        check_reset_input(1'b0);
        end_test("reset state");

        for (int t = 0; t < 6; t++) begin
            len = 1 + int'($urandom % 12);
            bar = bar_hit_t'(1 << ($urandom % 7));
            send_rx_tlp(1'b0, len, bar);
            check_rx_tlp(1'b0, len, bar);
        end
        end_test("receive DW0 aligned");

        for (int t = 0; t < 10; t++) begin
            len = 3 + int'($urandom % 14);
            bar = bar_hit_t'(1 << ($urandom % 7));
            send_rx_tlp(1'b1, len, bar);
            check_rx_tlp(1'b1, len, bar);
        end
        end_test("receive DW2 start");

        // Lengths 5, 6, 9 and 10 end at DW2 or DW3
        for (int t = 0; t < 4; t++) begin
            len = 5 + (t % 2) + 4 * (t / 2);
            bar = bar_hit_t'(1 << ($urandom % 7));
            send_rx_tlp(1'b1, len, bar);
            check_rx_tlp(1'b1, len, bar);
        end
        end_test("receive end stall");

        run_tx_test();
        end_test("transmit skid");

        link_up = 1'b1;
        for (int c = 0; c < 40; c++) begin
            @(negedge clk_pcie);
            assert (led_state) else log_error("led_state low with link up");
            next_cycle();
        end
        link_up = 1'b0;
        @(negedge clk_pcie);
        last_led = led_state;
        run_len  = 0;
        toggles  = 0;
        next_cycle();
        for (int c = 0; c < 80; c++) begin
            @(negedge clk_pcie);
            if (led_state != last_led) begin
                if (toggles > 0) begin
                    assert (run_len == 16)
                        else log_error($sformatf("led_state held %0d cycles", run_len));
                end
                toggles++;
                run_len = 0;
            end
            run_len++;
            last_led = led_state;
            next_cycle();
        end
        if (toggles < 3) begin
            log_failure("led_state did not blink with the link down");
        end
        end_test("link LED");

        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        #(CLK_HALF * 2 * 4000);
        $display("Simulation did not finish within the cycle limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== pcie_tlp_bridge.f ====
+incdir+source
source/pcie_core_pkg.sv
source/tlp_stream_pkg.sv
source/tlp_rx_realign.sv
source/tlp_tx_skid.sv
source/link_state_led.sv
source/pcie_tlp_bridge.sv
testbench/tb_pcie_tlp_bridge.sv

// ==== Makefile ====
# Verilator build and run for the pcie_tlp_bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_pcie_tlp_bridge
FILELIST  ?= pcie_tlp_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := source/tlp_bridge_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the exit status of the simulator
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
